// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal --timescale 1ns/1ps
TOP       := tb_mat_mul
FILELIST  := all.f
PASS_MSG  := TB PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: all.f
+incdir+common
+incdir+testbench
common/cplx_pkg.sv
common/seq_pkg.sv
hw/mat_seq/elem_sequencer.sv
hw/mat_seq/matrix_bank.sv
hw/mat_seq/cplx_dot_unit.sv
hw/mat_mul_top.sv
testbench/tb_mat_mul.sv

// File: common/cplx_pkg.sv
/*
 * Complex fixed-point types. A vector is one row or one column;
 * a matrix is indexed as m[row][col]. Products keep full precision.
 */
`include "mat_defines.svh"

package cplx_pkg;

    // One real or imaginary part
    typedef logic signed [`DATA_W-1:0] sample_t;

    typedef struct packed {
        sample_t re;
        sample_t im;
    } cplx_t;

    // One row or column
    typedef cplx_t [`MAT_N-1:0] cvec_t;

    // Row first, then column
    typedef cvec_t [`MAT_N-1:0] cmat_t;

    // Full-precision product of two parts
    typedef logic signed [2*`DATA_W-1:0] prod_t;

endpackage

// File: common/mat_defines.svh
/*
 * Matrix size and fixed-point format shared by the RTL and the testbench.
 * Parts are signed Q7.11; the datapath assumes a square matrix of order 4.
 */
`ifndef MAT_DEFINES_SVH
`define MAT_DEFINES_SVH

// Matrix order
`define MAT_N 4

// Signed fixed-point format of one real or imaginary part
`define INT_BITS 7
`define FRAC_BITS 11

// Width of one part
`define DATA_W (`INT_BITS + `FRAC_BITS)

`endif

// File: common/seq_pkg.sv
/*
 * Sequencer state and element index types.
 * The index width covers one row or column of a MAT_N matrix.
 */
`include "mat_defines.svh"

package seq_pkg;

    typedef enum logic {
        SEQ_IDLE = 1'b0,
        SEQ_RUN  = 1'b1
    } seq_state_e;

    // Row or column index
    typedef logic [$clog2(`MAT_N)-1:0] idx_t;

endpackage

// File: hw/mat_mul_top.sv
/*
 * 4x4 complex matrix multiplier, C = A x B.
 * Element k of a run leaves 2 cycles after it is selected, with its
 * row and column. Results are one-cycle pulses without back-pressure.
 */
`timescale 1ns/1ps

module mat_mul_top
    import cplx_pkg::*;
    import seq_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  start_i,
    input  cmat_t a_mat_i,
    input  cmat_t b_mat_i,
    output cplx_t c_o,
    output idx_t  c_row_o,
    output idx_t  c_col_o,
    output logic  c_valid_o,
    output logic  busy_o
);

    logic  load;
    idx_t  row_sel;
    idx_t  col_sel;
    logic  sel_valid;
    cvec_t a_row;
    cvec_t b_col;

    elem_sequencer elem_sequencer_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_i     (start_i),
        .load_o      (load),
        .row_sel_o   (row_sel),
        .col_sel_o   (col_sel),
        .sel_valid_o (sel_valid),
        .busy_o      (busy_o)
    );

    matrix_bank matrix_bank_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_i    (load),
        .a_mat_i   (a_mat_i),
        .b_mat_i   (b_mat_i),
        .row_sel_i (row_sel),
        .col_sel_i (col_sel),
        .a_row_o   (a_row),
        .b_col_o   (b_col)
    );

    cplx_dot_unit cplx_dot_unit_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid_i (sel_valid),
        .row_i      (row_sel),
        .col_i      (col_sel),
        .a_vec_i    (a_row),
        .b_vec_i    (b_col),
        .c_o        (c_o),
        .row_o      (c_row_o),
        .col_o      (c_col_o),
        .valid_o    (c_valid_o)
    );

endmodule

// File: hw/mat_seq/cplx_dot_unit.sv
/*
 * Complex dot product of two MAT_N vectors, fixed latency of 2 cycles.
 * Sums are kept at full precision with guard bits, shifted right by
 * FRAC_BITS (floor) and wrapped to DATA_W. No saturation.
 */
`timescale 1ns/1ps
`include "mat_defines.svh"

module cplx_dot_unit
    import cplx_pkg::*;
    import seq_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  in_valid_i,
    input  idx_t  row_i,
    input  idx_t  col_i,
    input  cvec_t a_vec_i,
    input  cvec_t b_vec_i,
    output cplx_t c_o,
    output idx_t  row_o,
    output idx_t  col_o,
    output logic  valid_o
);

    // Two products per term, MAT_N terms per sum
    localparam int GUARD = $clog2(2 * `MAT_N);
    localparam int ACC_W = $bits(prod_t) + GUARD;

    // Stage 1 partial products
    prod_t p_rr [`MAT_N];
    prod_t p_ii [`MAT_N];
    prod_t p_ri [`MAT_N];
    prod_t p_ir [`MAT_N];
    idx_t  row_s1;
    idx_t  col_s1;
    logic  valid_s1;

    logic signed [ACC_W-1:0] acc_re;
    logic signed [ACC_W-1:0] acc_im;
    logic signed [ACC_W-1:0] shr_re;
    logic signed [ACC_W-1:0] shr_im;

    always_ff @(posedge clk) begin
        for (int k = 0; k < `MAT_N; k++) begin
            p_rr[k] <= a_vec_i[k].re * b_vec_i[k].re;
            p_ii[k] <= a_vec_i[k].im * b_vec_i[k].im;
            p_ri[k] <= a_vec_i[k].re * b_vec_i[k].im;
            p_ir[k] <= a_vec_i[k].im * b_vec_i[k].re;
        end
        row_s1 <= row_i;
        col_s1 <= col_i;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_s1 <= 1'b0;
        end else begin
            valid_s1 <= in_valid_i;
        end
    end

    // Stage 2 adder tree
    always_comb begin
        acc_re = '0;
        acc_im = '0;
        for (int k = 0; k < `MAT_N; k++) begin
            acc_re = acc_re + ACC_W'(p_rr[k]) - ACC_W'(p_ii[k]);
            acc_im = acc_im + ACC_W'(p_ri[k]) + ACC_W'(p_ir[k]);
        end
        shr_re = acc_re >>> `FRAC_BITS;
        shr_im = acc_im >>> `FRAC_BITS;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            c_o     <= '0;
            valid_o <= 1'b0;
        end else begin
            // Upper bits dropped, so large sums wrap
            c_o.re  <= shr_re[`DATA_W-1:0];
            c_o.im  <= shr_im[`DATA_W-1:0];
            valid_o <= valid_s1;
        end
    end

    always_ff @(posedge clk) begin
        row_o <= row_s1;
        col_o <= col_s1;
    end

    a_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        valid_o == $past(in_valid_i, 2)
    );

endmodule

// File: hw/mat_seq/elem_sequencer.sv
/*
 * Walks the result elements in row-major order, one per cycle.
 * A start seen while running is dropped. load_o is combinational from
 * the idle state and start_i, so start_i must be low during reset.
 */
`timescale 1ns/1ps
`include "mat_defines.svh"

module elem_sequencer
    import seq_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic start_i,
    output logic load_o,
    output idx_t row_sel_o,
    output idx_t col_sel_o,
    output logic sel_valid_o,
    output logic busy_o
);

    localparam int IDX_W = $bits(idx_t);
    localparam int CNT_W = 2 * IDX_W;
    localparam int LAST  = `MAT_N * `MAT_N - 1;

    seq_state_e       state;
    logic [CNT_W-1:0] elem_cnt;

    // Start is accepted only when idle
    assign load_o = (state == SEQ_IDLE) && start_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= SEQ_IDLE;
            elem_cnt <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (start_i) begin
                        state    <= SEQ_RUN;
                        elem_cnt <= '0;
                    end
                end
                SEQ_RUN: begin
                    // Wraps back to zero on the last element
                    elem_cnt <= elem_cnt + 1'b1;
                    if (elem_cnt == CNT_W'(LAST)) begin
                        state <= SEQ_IDLE;
                    end
                end
                default: begin
                    state    <= SEQ_IDLE;
                    elem_cnt <= '0;
                end
            endcase
        end
    end

    // Upper half is the row, lower half the column
    assign row_sel_o = elem_cnt[CNT_W-1:IDX_W];
    assign col_sel_o = elem_cnt[IDX_W-1:0];

    assign sel_valid_o = (state == SEQ_RUN);
    assign busy_o      = (state == SEQ_RUN);

    // No new load while a run is in progress
    a_no_load_in_run: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == SEQ_RUN) |-> !load_o
    );

    // Every accepted start gives exactly one full run
    a_run_length: assert property (
        @(posedge clk) disable iff (!rst_n)
        load_o |=> busy_o [*LAST+1] ##1 !busy_o
    );

endmodule

// File: hw/mat_seq/matrix_bank.sv
/*
 * Register bank for A and B, written only on load so the inputs may
 * change during a run. Row and column selection is combinational.
 * The bank reads as zero until the first load.
 */
`timescale 1ns/1ps
`include "mat_defines.svh"

module matrix_bank
    import cplx_pkg::*;
    import seq_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  load_i,
    input  cmat_t a_mat_i,
    input  cmat_t b_mat_i,
    input  idx_t  row_sel_i,
    input  idx_t  col_sel_i,
    output cvec_t a_row_o,
    output cvec_t b_col_o
);

    cmat_t a_q;
    cmat_t b_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a_q <= '0;
            b_q <= '0;
        end else if (load_i) begin
            a_q <= a_mat_i;
            b_q <= b_mat_i;
        end
    end

    // A is stored by row, so a row is one slice
    assign a_row_o = a_q[row_sel_i];

    // Column of B is gathered across the rows
    always_comb begin
        for (int k = 0; k < `MAT_N; k++) begin
            b_col_o[k] = b_q[k][col_sel_i];
        end
    end

endmodule

// File: testbench/tb_mat_ref.svh
/*
 * Reference model and random source for the matrix testbench.
 * Included inside the testbench module after the package imports.
 * The xorshift state is shared by every caller.
 */
`ifndef TB_MAT_REF_SVH
`define TB_MAT_REF_SVH

// Fixed seed
logic [31:0] rng_state = 32'd85449;

// One 32-bit xorshift step
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
endfunction

// Every part takes the full signed range
function automatic cmat_t rand_matrix();
    cmat_t       m;
    logic [31:0] r;
    for (int i = 0; i < `MAT_N; i++) begin
        for (int j = 0; j < `MAT_N; j++) begin
            r = next_rand();
            m[i][j].re = r[`DATA_W-1:0];
            r = next_rand();
            m[i][j].im = r[`DATA_W-1:0];
        end
    end
    return m;
endfunction

// C = A x B with full-precision sums, floor shift, then wrap
function automatic cmat_t ref_matmul(input cmat_t a, input cmat_t b);
    cmat_t  c;
    longint sum_re;
    longint sum_im;
    longint ar;
    longint ai;
    longint br;
    longint bi;
    for (int i = 0; i < `MAT_N; i++) begin
        for (int j = 0; j < `MAT_N; j++) begin
            sum_re = 0;
            sum_im = 0;
            for (int k = 0; k < `MAT_N; k++) begin
                ar = a[i][k].re;
                ai = a[i][k].im;
                br = b[k][j].re;
                bi = b[k][j].im;
                sum_re = sum_re + ar * br - ai * bi;
                sum_im = sum_im + ar * bi + ai * br;
            end
            sum_re = sum_re >>> `FRAC_BITS;
            sum_im = sum_im >>> `FRAC_BITS;
            c[i][j].re = sum_re[`DATA_W-1:0];
            c[i][j].im = sum_im[`DATA_W-1:0];
        end
    end
    return c;
endfunction

`endif

// File: testbench/tb_mat_mul.sv
/*
 * Testbench for mat_mul_top. Inputs change on the falling edge and
 * outputs are sampled there as well. Each accepted run is queued with
 * its expected matrix and accepting edge for the monitor.
 */
`timescale 1ns/1ps
`include "mat_defines.svh"

module tb_mat_mul
    import cplx_pkg::*;
    import seq_pkg::*;
();

    localparam int N_ELEM       = `MAT_N * `MAT_N;
    localparam int RESET_CYCLES = 10;
    localparam int IDLE_CYCLES  = 20;
    localparam int GAP_CYCLES   = 6;
    localparam int RANDOM_RUNS  = 20;
    // Identity, random runs, latch run, two back-to-back runs
    localparam int NUM_RUNS     = 1 + RANDOM_RUNS + 1 + 2;
    localparam int TIMEOUT_CYCLES =
        2 * (NUM_RUNS * (18 + GAP_CYCLES) + IDLE_CYCLES) + RESET_CYCLES;

    logic  clk = 1'b0;
    logic  rst_n;
    logic  start_i;
    cmat_t a_mat_i;
    cmat_t b_mat_i;
    cplx_t c_o;
    idx_t  c_row_o;
    idx_t  c_col_o;
    logic  c_valid_o;
    logic  busy_o;

    // Expected result and accepting edge of each outstanding run
    cmat_t exp_q[$];
    int    accept_q[$];
    int    elem_idx    = 0;
    int    valid_count = 0;
    int    cycle_cnt   = 0;
    cplx_t exp_elem;

    `include "tb_mat_ref.svh"

    mat_mul_top mat_mul_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_i   (start_i),
        .a_mat_i   (a_mat_i),
        .b_mat_i   (b_mat_i),
        .c_o       (c_o),
        .c_row_o   (c_row_o),
        .c_col_o   (c_col_o),
        .c_valid_o (c_valid_o),
        .busy_o    (busy_o)
    );

    always #5 clk = ~clk;

    task automatic stop_with_error(input string msg);
        $display("Error at %0t: %s", $time, msg);
        $display("TB FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input longint got, input longint expected);
        if (got !== expected) begin
            $display("[FAIL] %0t: %s is %0d, expected %0d", $time, what, got, expected);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic cmat_t identity_matrix();
        cmat_t m;
        m = '0;
        for (int i = 0; i < `MAT_N; i++) begin
            m[i][i].re = sample_t'(1 << `FRAC_BITS);
        end
        return m;
    endfunction

    // Called on a falling edge; returns on the falling edge after acceptance
    task automatic start_run(input cmat_t a, input cmat_t b, input cmat_t expected,
                             input bit hold_start);
        bit waited;
        a_mat_i = a;
        b_mat_i = b;
        start_i = 1'b1;
        waited  = busy_o;
        while (busy_o) begin
            @(negedge clk);
        end
        // A run lasts N_ELEM cycles from its accepting edge
        if (waited) begin
            check_value("cycle busy_o falls", cycle_cnt, accept_q[$] + N_ELEM);
        end
        // Idle now, so the next rising edge accepts
        exp_q.push_back(expected);
        accept_q.push_back(cycle_cnt + 1);
        @(negedge clk);
        if (!hold_start) begin
            start_i = 1'b0;
        end
    endtask

    task automatic wait_run_done();
        while (busy_o) begin
            @(negedge clk);
        end
        check_value("cycle busy_o falls", cycle_cnt, accept_q[$] + N_ELEM);
        repeat (GAP_CYCLES) @(negedge clk);
        check_value("runs still outstanding", exp_q.size(), 0);
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            stop_with_error($sformatf("timeout, test not done after %0d cycles", cycle_cnt));
        end
    end

    // Monitor
    always @(negedge clk) begin
        if (rst_n) begin
            if (c_valid_o) begin
                if (exp_q.size() == 0) begin
                    stop_with_error("valid pulse seen with no run outstanding");
                end else begin
                    if (elem_idx == 0) begin
                        check_value("cycle of first result", cycle_cnt, accept_q[0] + 2);
                    end
                    check_value("c_row_o", c_row_o, elem_idx / `MAT_N);
                    check_value("c_col_o", c_col_o, elem_idx % `MAT_N);
                    exp_elem = exp_q[0][elem_idx / `MAT_N][elem_idx % `MAT_N];
                    check_value("c_o.re", c_o.re, exp_elem.re);
                    check_value("c_o.im", c_o.im, exp_elem.im);
                    elem_idx    = elem_idx + 1;
                    valid_count = valid_count + 1;
                    if (elem_idx == N_ELEM) begin
                        void'(exp_q.pop_front());
                        void'(accept_q.pop_front());
                        elem_idx = 0;
                    end
                end
            end else if (elem_idx != 0) begin
                stop_with_error("valid pulses of one run are not on consecutive cycles");
            end
        end
    end

    initial begin
        cmat_t a;
        cmat_t b;
        cmat_t a_next;
        cmat_t b_next;
        $timeformat(-9, 0, " ns", 0);
        rst_n   = 1'b0;
        start_i = 1'b0;
        a_mat_i = '0;
        b_mat_i = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        // Quiet while idle
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            check_value("busy_o while idle", busy_o, 0);
            check_value("c_valid_o while idle", c_valid_o, 0);
            check_value("c_o.re while idle", c_o.re, 0);
            check_value("c_o.im while idle", c_o.im, 0);
        end

        // Identity times B gives B
        b = rand_matrix();
        start_run(identity_matrix(), b, b, 1'b0);
        wait_run_done();

        repeat (RANDOM_RUNS) begin
            a = rand_matrix();
            b = rand_matrix();
            start_run(a, b, ref_matmul(a, b), 1'b0);
            wait_run_done();
        end

        // New inputs and a second start in the middle of a run
        a      = rand_matrix();
        b      = rand_matrix();
        a_next = rand_matrix();
        b_next = rand_matrix();
        start_run(a, b, ref_matmul(a, b), 1'b0);
        repeat (3) @(negedge clk);
        check_value("busy_o at extra start", busy_o, 1);
        a_mat_i = a_next;
        b_mat_i = b_next;
        start_i = 1'b1;
        @(negedge clk);
        start_i = 1'b0;
        wait_run_done();

        // start_i held high over two runs
        a      = rand_matrix();
        b      = rand_matrix();
        a_next = rand_matrix();
        b_next = rand_matrix();
        start_run(a, b, ref_matmul(a, b), 1'b1);
        start_run(a_next, b_next, ref_matmul(a_next, b_next), 1'b0);
        wait_run_done();

        check_value("number of valid pulses", valid_count, NUM_RUNS * N_ELEM);
        $display("TB PASSED");
        $finish;
    end

endmodule
